//--- files.f
hw/interp_pkg.sv
hw/tap_product_stage.sv
hw/pair_sum_stage.sv
hw/normalize_stage.sv
hw/interp_top.sv
testbench/tb_clock_gen.sv
testbench/interp_checker.sv
testbench/interp_props.sv
testbench/tb_interp.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interpolation filter bank testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
	--top-module tb_interp -f files.f \
	--Mdir "$BUILD_DIR" -o sim_interp; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/sim_interp" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
	exit 0
fi

echo "pass message not found in $LOG"
exit 1

//--- testbench/tb_interp.sv
`timescale 1ns/1ps

module tb_interp
	import interp_pkg::*;
();

	logic       clk;
	logic       arst_n;
	window_t    window;
	filt_bank_t phases;

	tb_clock_gen clk_gen (.clk(clk), .arst_n(arst_n));

	interp_top dut (.clk(clk), .arst_n(arst_n), .window(window), .phases(phases));

	interp_checker chk (.clk(clk), .arst_n(arst_n), .window(window), .phases(phases));

	// ------------------------------
	// stimulus helpers
	// ------------------------------

	task automatic drive(input window_t w);
		@(posedge clk);
		window <= w;
	endtask

	// lets the last window drain through all three stages
	task automatic settle();
		repeat (4) @(posedge clk);
	endtask

	// bounded wait for arst_n to reach the given level
	task automatic wait_for_arst(input logic level, output bit reached);
		int cycles;
		cycles = 0;
		while (arst_n !== level && cycles < 20) begin
			@(posedge clk);
			cycles++;
		end
		reached = (arst_n === level);
	endtask

	function automatic window_t flat_window(input sample_t v);
		logic [$bits(window_t)-1:0] bits;
		for (int k = 0; k < NUM_TAPS; k++) begin
			bits[k*SAMPLE_W +: SAMPLE_W] = v;
		end
		return window_t'(bits);
	endfunction

	function automatic window_t one_tap(input int k, input sample_t v);
		logic [$bits(window_t)-1:0] bits;
		bits = '0;
		bits[k*SAMPLE_W +: SAMPLE_W] = v;	// tap0 in the low byte
		return window_t'(bits);
	endfunction

	function automatic sample_t rand_sample();
		int sel;
		sel = $urandom_range(7, 0);
		if (sel == 0) begin
			return sample_t'(-128);	// extremes show up often
		end else if (sel == 1) begin
			return sample_t'(127);
		end else begin
			return sample_t'($urandom);
		end
	endfunction

	// ------------------------------
	// tests
	// ------------------------------

	task automatic run_flat();
		sample_t levels [5];
		levels = '{sample_t'(0), sample_t'(5), sample_t'(-7), sample_t'(127), sample_t'(-128)};
		chk.begin_test("flat");
		foreach (levels[i]) begin
			drive(flat_window(levels[i]));
		end
		settle();
		chk.end_test();
	endtask

	task automatic run_impulse();
		chk.begin_test("impulse");
		for (int k = 0; k < NUM_TAPS; k++) begin
			drive(one_tap(k, sample_t'(64)));
			drive(one_tap(k, sample_t'(-64)));
		end
		settle();
		chk.end_test();
	endtask

	task automatic run_rounding();
		chk.begin_test("rounding");
		drive(one_tap(0, sample_t'(1)));
		drive(one_tap(0, sample_t'(-1)));
		drive(one_tap(1, sample_t'(1)));	// negative coefficient
		drive(one_tap(1, sample_t'(-1)));
		drive(one_tap(2, sample_t'(-3)));
		drive(one_tap(0, sample_t'(-1)) | one_tap(3, sample_t'(1)));
		settle();
		chk.end_test();
	endtask

	task automatic run_stream();
		window_t w;
		chk.begin_test("stream");
		for (int n = 0; n < 200; n++) begin
			w.tap0 = rand_sample();
			w.tap1 = rand_sample();
			w.tap2 = rand_sample();
			w.tap3 = rand_sample();
			w.tap4 = rand_sample();
			w.tap5 = rand_sample();
			drive(w);	// back to back, three windows in flight
		end
		settle();
		chk.end_test();
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		bit seen_low;
		bit released;
		window = '0;
		seen_low = 1'b0;
		released = 1'b0;
		void'($urandom(32'he5f8_6109));
		chk.begin_test("reset");	// covers the reset cycles too
		wait_for_arst(1'b0, seen_low);
		if (seen_low) begin
			wait_for_arst(1'b1, released);
		end
		if (!seen_low) begin
			$display("timeout: reset was not asserted within 20 cycles");
			$display("RESULT: FAIL");
		end else if (!released) begin
			$display("timeout: reset was not released within 20 cycles");
			$display("RESULT: FAIL");
		end else begin
			settle();
			chk.end_test();
			run_flat();
			run_impulse();
			run_rounding();
			run_stream();
			$display("total checks %0d errors %0d assertion failures %0d",
				chk.total_checks, chk.total_errors, dut.props.assert_fails);
			if (chk.total_errors == 0 && dut.props.assert_fails == 0) begin
				$display("RESULT: PASS");
			end else begin
				$display("RESULT: FAIL");
			end
		end
		$finish;
	end

	initial begin
		#100_000;	// far beyond the ~260 cycles of the run
		$display("timeout: simulation did not finish within 100 us");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- testbench/interp_props.sv
`timescale 1ns/1ps

module interp_props
	import interp_pkg::*;
(
	input logic       clk,
	input logic       arst_n,
	input window_t    window,
	input filt_bank_t phases
);

	int assert_fails;	// read by the testbench top

	initial begin
		assert_fails = 0;
	end

	reset_clears: assert property (@(posedge clk) !arst_n |-> phases == '0)
		else begin
			$error("phases not zero while arst_n is low");
			assert_fails++;
		end

	no_unknown: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(phases))
		else begin
			$error("phases carries unknown bits after reset");
			assert_fails++;
		end

	// a zero window held for the whole latency leaves zero behind it
	zero_in_zero_out: assert property (@(posedge clk) disable iff (!arst_n)
		(window == '0 && $past(window) == '0 && $past(window, 2) == '0
			&& $past(window, 3) == '0) |-> phases == '0)
		else begin
			$error("zero window did not give zero phases");
			assert_fails++;
		end

endmodule

bind interp_top interp_props props (
	.clk    (clk),
	.arst_n (arst_n),
	.window (window),
	.phases (phases)
);

//--- testbench/interp_checker.sv
`timescale 1ns/1ps

module interp_checker
	import interp_pkg::*;
(
	input logic       clk,
	input logic       arst_n,
	input window_t    window,
	input filt_bank_t phases
);

	int         test_errors;
	int         total_errors;
	int         total_checks;
	string      test_name;
	filt_bank_t exp_pipe [3];	// expected values in flight

	initial begin
		test_errors  = 0;
		total_errors = 0;
		total_checks = 0;
		test_name    = "none";
	end

	// ------------------------------
	// reference model
	// ------------------------------

	function automatic filt_bank_t ref_phases(input window_t w);
		int         samp [NUM_TAPS];
		int         sum;
		int         quo;
		filt_bank_t res;
		samp[0] = int'(w.tap0);
		samp[1] = int'(w.tap1);
		samp[2] = int'(w.tap2);
		samp[3] = int'(w.tap3);
		samp[4] = int'(w.tap4);
		samp[5] = int'(w.tap5);
		for (int p = 0; p < NUM_PHASES; p++) begin
			sum = 0;
			for (int t = 0; t < NUM_TAPS; t++) begin
				sum += samp[t] * int'(PHASE_COEF[p][t]);
			end
			quo = sum / 64;	// truncates toward zero
			if (sum < 0 && sum % 64 != 0) begin
				quo = quo - 1;	// floor for negative remainders
			end
			res[p] = filt_out_t'(quo);
		end
		return res;
	endfunction

	// three-cycle delay, cleared by reset like the DUT registers
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_pipe[0] <= '0;
			exp_pipe[1] <= '0;
			exp_pipe[2] <= '0;
		end else begin
			exp_pipe[0] <= ref_phases(window);
			exp_pipe[1] <= exp_pipe[0];
			exp_pipe[2] <= exp_pipe[1];
		end
	end

	// ------------------------------
	// comparison
	// ------------------------------

	always @(negedge clk) begin
		filt_out_t got;
		filt_out_t want;
		for (int p = 0; p < NUM_PHASES; p++) begin
			got  = phases[p];
			want = exp_pipe[2][p];
			total_checks++;
			if (got !== want) begin
				$display("ERROR t=%0t phase %0d expected %0d actual %0d",
					$time, p + 1, want, got);
				test_errors++;
				total_errors++;
			end
		end
	end

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("test %s errors %0d", test_name, test_errors);
	endtask

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	initial begin
		arst_n = 1'b1;
		#10;
		arst_n = 1'b0;	// falling edge clears the pipeline
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;	// released on the 8th rising edge
	end

endmodule

//--- hw/interp_top.sv
`timescale 1ns/1ps

module interp_top
	import interp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  window_t    window,	// new window taken on every edge
	output filt_bank_t phases	// three cycles after the window
);

	// ------------------------------
	// inter-stage buses
	// ------------------------------

	prod_bank_t prods;	// 90 registered products
	pair_bank_t pairs;	// 45 registered pair sums

	// ------------------------------
	// pipeline
	// ------------------------------

	tap_product_stage u_tap_product_stage (
		.clk    (clk),
		.arst_n (arst_n),
		.window (window),
		.prods  (prods)
	);

	pair_sum_stage u_pair_sum_stage (
		.clk    (clk),
		.arst_n (arst_n),
		.prods  (prods),
		.pairs  (pairs)
	);

	normalize_stage u_normalize_stage (
		.clk    (clk),
		.arst_n (arst_n),
		.pairs  (pairs),
		.phases (phases)
	);

endmodule

//--- hw/normalize_stage.sv
`timescale 1ns/1ps

module normalize_stage
	import interp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  pair_bank_t pairs,
	output filt_bank_t phases
);

	// ------------------------------
	// final sum and scaling
	// ------------------------------

	acc_t       acc [NUM_PHASES];	// full weighted sum per phase
	acc_t       scaled [NUM_PHASES];	// after the divide by 64
	filt_bank_t phase_next;

	for (genvar p = 0; p < NUM_PHASES; p++) begin : g_phase
		assign acc[p] = acc_t'(pairs[p].p01)
			+ acc_t'(pairs[p].p23)
			+ acc_t'(pairs[p].p45);

		// arithmetic shift, so odd negative sums round toward minus infinity
		assign scaled[p] = acc[p] >>> NORM_SHIFT;

		// the row sum of 64 keeps every result near the sample range,
		// well inside 11 bits, so dropping the upper bits never wraps
		assign phase_next[p] = scaled[p][OUT_W-1:0];
	end

	// ------------------------------
	// output register
	// ------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			phases <= '0;	// reads all zeros in reset
		end else begin
			phases <= phase_next;
		end
	end

endmodule

//--- hw/pair_sum_stage.sv
`timescale 1ns/1ps

module pair_sum_stage
	import interp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  prod_bank_t prods,
	output pair_bank_t pairs
);

	// ------------------------------
	// first level of the sum tree
	// ------------------------------

	pair_bank_t pair_next;

	for (genvar p = 0; p < NUM_PHASES; p++) begin : g_phase
		// sign-extend to the pair width before the add
		assign pair_next[p].p01 = pair_t'(prods[p][0]) + pair_t'(prods[p][1]);
		assign pair_next[p].p23 = pair_t'(prods[p][2]) + pair_t'(prods[p][3]);	// main taps
		assign pair_next[p].p45 = pair_t'(prods[p][4]) + pair_t'(prods[p][5]);
	end

	// ------------------------------
	// stage register
	// ------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pairs <= '0;
		end else begin
			pairs <= pair_next;	// one cycle behind prods
		end
	end

endmodule

//--- hw/tap_product_stage.sv
`timescale 1ns/1ps

module tap_product_stage
	import interp_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  window_t    window,
	output prod_bank_t prods
);

	// ------------------------------
	// window split
	// ------------------------------

	sample_t samples [NUM_TAPS];	// samples[k] feeds tap k

	assign samples[0] = window.tap0;	// low byte
	assign samples[1] = window.tap1;
	assign samples[2] = window.tap2;
	assign samples[3] = window.tap3;
	assign samples[4] = window.tap4;
	assign samples[5] = window.tap5;	// high byte

	// ------------------------------
	// constant products
	// ------------------------------

	prod_bank_t prod_next;

	// every coefficient is a constant, so each product reduces to a few
	// shifts and adds; both operands are widened first so that the
	// multiply is evaluated at the full product width
	for (genvar p = 0; p < NUM_PHASES; p++) begin : g_phase
		for (genvar t = 0; t < NUM_TAPS; t++) begin : g_tap
			assign prod_next[p][t] = prod_t'(samples[t]) * prod_t'(PHASE_COEF[p][t]);
		end
	end

	// ------------------------------
	// stage register
	// ------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prods <= '0;	// all 90 products cleared
		end else begin
			prods <= prod_next;	// new window every cycle
		end
	end

endmodule

//--- hw/interp_pkg.sv
package interp_pkg;

	// ------------------------------
	// filter bank dimensions
	// ------------------------------

	localparam int NUM_TAPS   = 6;	// samples per window
	localparam int NUM_PHASES = 15;	// one filter per fractional phase
	localparam int SAMPLE_W   = 8;	// signed input sample
	localparam int COEF_W     = 8;	// covers -11 .. 63
	localparam int PROD_W     = 14;	// 63 * -128 still fits
	localparam int PAIR_W     = PROD_W + 1;	// one carry bit per pair
	localparam int ACC_W      = 17;	// full sum of three pairs, with margin
	localparam int OUT_W      = 11;	// phase result
	localparam int NORM_SHIFT = 6;	// divide by the row sum of 64

	// ------------------------------
	// scalar types
	// ------------------------------

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0]   coef_t;
	typedef logic signed [PROD_W-1:0]   prod_t;
	typedef logic signed [PAIR_W-1:0]   pair_t;
	typedef logic signed [ACC_W-1:0]    acc_t;
	typedef logic signed [OUT_W-1:0]    filt_out_t;

	// tap0 in the low byte, same split as the combinational bank
	typedef struct packed {
		sample_t tap5;
		sample_t tap4;
		sample_t tap3;
		sample_t tap2;
		sample_t tap1;
		sample_t tap0;
	} window_t;

	// first level of the sum tree for one phase
	typedef struct packed {
		pair_t p45;
		pair_t p23;
		pair_t p01;
	} pair_sums_t;

	// ------------------------------
	// pipeline buses
	// ------------------------------

	typedef prod_t      [NUM_PHASES-1:0][NUM_TAPS-1:0] prod_bank_t;	// [phase][tap]
	typedef pair_sums_t [NUM_PHASES-1:0]               pair_bank_t;
	typedef filt_out_t  [NUM_PHASES-1:0]               filt_bank_t;	// index 0 = phase 1

	// ------------------------------
	// coefficient set
	// ------------------------------

	// rows are phases 1..15, columns taps 0..5
	// each row sums to 64, so a flat window passes unchanged
	localparam coef_t PHASE_COEF [NUM_PHASES][NUM_TAPS] = '{
		'{8'sd1, -8'sd3,  8'sd63,  8'sd4,  -8'sd2,  8'sd1},
		'{8'sd1, -8'sd5,  8'sd62,  8'sd8,  -8'sd3,  8'sd1},
		'{8'sd2, -8'sd8,  8'sd60,  8'sd13, -8'sd4,  8'sd1},
		'{8'sd3, -8'sd10, 8'sd58,  8'sd17, -8'sd5,  8'sd1},
		'{8'sd3, -8'sd11, 8'sd52,  8'sd26, -8'sd8,  8'sd2},
		'{8'sd2, -8'sd9,  8'sd47,  8'sd31, -8'sd10, 8'sd3},
		'{8'sd3, -8'sd11, 8'sd45,  8'sd34, -8'sd10, 8'sd3},
		'{8'sd3, -8'sd11, 8'sd40,  8'sd40, -8'sd11, 8'sd3},	// half-sample, symmetric
		'{8'sd3, -8'sd10, 8'sd34,  8'sd45, -8'sd11, 8'sd3},
		'{8'sd3, -8'sd10, 8'sd31,  8'sd47, -8'sd9,  8'sd2},
		'{8'sd2, -8'sd8,  8'sd26,  8'sd52, -8'sd11, 8'sd3},
		'{8'sd1, -8'sd5,  8'sd17,  8'sd58, -8'sd10, 8'sd3},
		'{8'sd1, -8'sd4,  8'sd13,  8'sd60, -8'sd8,  8'sd2},
		'{8'sd1, -8'sd3,  8'sd8,   8'sd62, -8'sd5,  8'sd1},
		'{8'sd1, -8'sd2,  8'sd4,   8'sd63, -8'sd3,  8'sd1}
	};

endpackage
